//--- flist.f
+incdir+source
source/block_xfer_pkg.sv
source/block_splitter.sv
source/lite_master.sv
source/word_memory.sv
source/block_xfer_top.sv
verif/block_xfer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the block transfer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f flist.f --top-module block_xfer_tb -o block_xfer_sim \
    > build.log 2>&1 \
    && ./obj_dir/block_xfer_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "test passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation PASSED"

//--- source/block_splitter.sv
`include "block_xfer_macros.svh"

module block_splitter
    import block_xfer_pkg::*;
(
    input  logic   clk,
    input  logic   i_reset,

    // Cache side.
    input  logic   i_start_read,
    input  logic   i_start_write,
    input  addr_t  i_addr,
    input  block_t i_block_data,
    output logic   o_busy,
    output logic   o_done,
    output logic   o_fault,
    output block_t o_block_data,

    // Word side towards the bus master.
    output logic   o_word_start,
    output logic   o_word_write,
    output addr_t  o_word_addr,
    output word_t  o_word_wdata,
    input  logic   i_word_done,
    input  resp_t  i_word_resp,
    input  word_t  i_word_rdata
);

    // One spare bit so an index overrun shows up.
    localparam int unsigned IDX_BITS = $clog2(`BLOCK_WORDS) + 1;

    logic                  busy_q;
    logic                  done_q;
    logic                  fault_q;
    logic                  word_start_q;
    logic [IDX_BITS - 1:0] index_q;
    logic                  write_q;
    addr_t                 base_q;
    block_t                block_q;

    logic                  start_accept;
    logic                  last_word;
    logic                  word_failed;
    logic [IDX_BITS - 2:0] word_sel;

    // Read wins when both strobes arrive together.
    assign start_accept = !busy_q && (i_start_read || i_start_write);
    assign last_word    = (index_q == IDX_BITS'(`BLOCK_WORDS - 1));
    assign word_failed  = (i_word_resp == SLVERR);
    assign word_sel     = index_q[IDX_BITS - 2:0];

    //----------------------------------------
    // Control.
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            fault_q      <= 1'b0;
            word_start_q <= 1'b0;
            index_q      <= '0;
        end else begin
            done_q       <= 1'b0;
            fault_q      <= 1'b0;
            word_start_q <= 1'b0;
            if (start_accept) begin
                busy_q       <= 1'b1;
                word_start_q <= 1'b1;
                index_q      <= '0;
            end else if (busy_q && done_q) begin
                // Busy covers the done cycle, then drops.
                busy_q <= 1'b0;
            end else if (busy_q && i_word_done) begin
                if (word_failed || last_word) begin
                    done_q  <= 1'b1;
                    fault_q <= word_failed;
                end else begin
                    index_q      <= index_q + IDX_BITS'(1);
                    word_start_q <= 1'b1;
                end
            end
        end
    end

    //----------------------------------------
    // Request and block data.
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (start_accept) begin
            write_q <= !i_start_read;
            base_q  <= i_addr;
            block_q <= i_block_data;
        end else if (busy_q && i_word_done && !write_q) begin
            block_q[word_sel] <= i_word_rdata;
        end
    end

    assign o_busy       = busy_q;
    assign o_done       = done_q;
    assign o_fault      = fault_q;
    assign o_block_data = block_q;

    assign o_word_start = word_start_q;
    assign o_word_write = write_q;
    assign o_word_addr  = base_q + addr_t'(index_q) * addr_t'(`WORD_BYTES);
    assign o_word_wdata = block_q[word_sel];

    // Completion must come before the index runs off the block.
    a_index_in_block : assert property (
        @(posedge clk) disable iff (i_reset)
        busy_q |-> (index_q <= IDX_BITS'(`BLOCK_WORDS - 1))
    );

endmodule

//--- source/block_xfer_macros.svh
`ifndef BLOCK_XFER_MACROS_SVH
`define BLOCK_XFER_MACROS_SVH

//----------------------------------------
// Data path sizes.
//----------------------------------------

// Width of one bus word.
`define WORD_BITS 32

// Bytes per bus word and so the address step between words.
`define WORD_BYTES (`WORD_BITS / 8)

// Bus words per cache block.
`define BLOCK_WORDS 8

// Byte address width.
`define ADDR_BITS 16

// Memory depth in words as a multiple of BLOCK_WORDS.
`define MEM_WORDS 256

`endif

//--- source/block_xfer_pkg.sv
`include "block_xfer_macros.svh"

package block_xfer_pkg;

    //----------------------------------------
    // Shared data types.
    //----------------------------------------

    // One bus word.
    typedef logic [`WORD_BITS - 1:0] word_t;

    // Byte address.
    typedef logic [`ADDR_BITS - 1:0] addr_t;

    // Cache block with word 0 at the lowest address.
    typedef word_t [`BLOCK_WORDS - 1:0] block_t;

    // Bus response codes in AXI encoding.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

endpackage

//--- source/block_xfer_top.sv
module block_xfer_top
    import block_xfer_pkg::*;
(
    input  logic   clk,
    input  logic   i_reset,
    input  logic   i_start_read,
    input  logic   i_start_write,
    input  addr_t  i_addr,
    input  block_t i_block_data,
    output logic   o_busy,
    output logic   o_done,
    output logic   o_fault,
    output block_t o_block_data
);

    //----------------------------------------
    // Internal nets.
    //----------------------------------------

    // Splitter to master.
    logic  s_word_start;
    logic  s_word_write;
    addr_t s_word_addr;
    word_t s_word_wdata;
    logic  s_word_done;
    resp_t s_word_resp;
    word_t s_word_rdata;

    // Master to memory.
    logic  s_awvalid;
    addr_t s_awaddr;
    logic  s_awready;
    logic  s_wvalid;
    word_t s_wdata;
    logic  s_wready;
    logic  s_bvalid;
    resp_t s_bresp;
    logic  s_bready;
    logic  s_arvalid;
    addr_t s_araddr;
    logic  s_arready;
    logic  s_rvalid;
    word_t s_rdata;
    resp_t s_rresp;
    logic  s_rready;

    //----------------------------------------
    // Block to word split.
    //----------------------------------------
    block_splitter u_splitter (
        .clk           ( clk           ),
        .i_reset       ( i_reset       ),
        .i_start_read  ( i_start_read  ),
        .i_start_write ( i_start_write ),
        .i_addr        ( i_addr        ),
        .i_block_data  ( i_block_data  ),
        .o_busy        ( o_busy        ),
        .o_done        ( o_done        ),
        .o_fault       ( o_fault       ),
        .o_block_data  ( o_block_data  ),
        .o_word_start  ( s_word_start  ),
        .o_word_write  ( s_word_write  ),
        .o_word_addr   ( s_word_addr   ),
        .o_word_wdata  ( s_word_wdata  ),
        .i_word_done   ( s_word_done   ),
        .i_word_resp   ( s_word_resp   ),
        .i_word_rdata  ( s_word_rdata  )
    );

    //----------------------------------------
    // Bus master.
    //----------------------------------------
    lite_master u_master (
        .clk          ( clk          ),
        .i_reset      ( i_reset      ),
        .i_word_start ( s_word_start ),
        .i_word_write ( s_word_write ),
        .i_word_addr  ( s_word_addr  ),
        .i_word_wdata ( s_word_wdata ),
        .o_word_done  ( s_word_done  ),
        .o_word_resp  ( s_word_resp  ),
        .o_word_rdata ( s_word_rdata ),
        .o_awvalid    ( s_awvalid    ),
        .o_awaddr     ( s_awaddr     ),
        .i_awready    ( s_awready    ),
        .o_wvalid     ( s_wvalid     ),
        .o_wdata      ( s_wdata      ),
        .i_wready     ( s_wready     ),
        .i_bvalid     ( s_bvalid     ),
        .i_bresp      ( s_bresp      ),
        .o_bready     ( s_bready     ),
        .o_arvalid    ( s_arvalid    ),
        .o_araddr     ( s_araddr     ),
        .i_arready    ( s_arready    ),
        .i_rvalid     ( s_rvalid     ),
        .i_rdata      ( s_rdata      ),
        .i_rresp      ( s_rresp      ),
        .o_rready     ( s_rready     )
    );

    //----------------------------------------
    // Word memory.
    //----------------------------------------
    word_memory u_memory (
        .clk       ( clk       ),
        .i_reset   ( i_reset   ),
        .i_awvalid ( s_awvalid ),
        .i_awaddr  ( s_awaddr  ),
        .o_awready ( s_awready ),
        .i_wvalid  ( s_wvalid  ),
        .i_wdata   ( s_wdata   ),
        .o_wready  ( s_wready  ),
        .o_bvalid  ( s_bvalid  ),
        .o_bresp   ( s_bresp   ),
        .i_bready  ( s_bready  ),
        .i_arvalid ( s_arvalid ),
        .i_araddr  ( s_araddr  ),
        .o_arready ( s_arready ),
        .o_rvalid  ( s_rvalid  ),
        .o_rdata   ( s_rdata   ),
        .o_rresp   ( s_rresp   ),
        .i_rready  ( s_rready  )
    );

endmodule

//--- source/lite_master.sv
module lite_master
    import block_xfer_pkg::*;
(
    input  logic  clk,
    input  logic  i_reset,

    // Word request side.
    input  logic  i_word_start,
    input  logic  i_word_write,
    input  addr_t i_word_addr,
    input  word_t i_word_wdata,
    output logic  o_word_done,
    output resp_t o_word_resp,
    output word_t o_word_rdata,

    // Write address and data.
    output logic  o_awvalid,
    output addr_t o_awaddr,
    input  logic  i_awready,
    output logic  o_wvalid,
    output word_t o_wdata,
    input  logic  i_wready,

    // Write response.
    input  logic  i_bvalid,
    input  resp_t i_bresp,
    output logic  o_bready,

    // Read address and data.
    output logic  o_arvalid,
    output addr_t o_araddr,
    input  logic  i_arready,
    input  logic  i_rvalid,
    input  word_t i_rdata,
    input  resp_t i_rresp,
    output logic  o_rready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP
    } state_t;

    state_t state_q;
    logic   awvalid_q;
    logic   wvalid_q;
    logic   arvalid_q;
    logic   bready_q;
    logic   rready_q;
    logic   done_q;
    logic   write_q;
    addr_t  addr_q;
    word_t  wdata_q;
    resp_t  resp_q;
    word_t  rdata_q;

    logic   accept;
    logic   b_fire;
    logic   r_fire;

    assign accept = (state_q == ST_IDLE) && i_word_start;
    assign b_fire = bready_q && i_bvalid;
    assign r_fire = rready_q && i_rvalid;

    //----------------------------------------
    // Transaction FSM.
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q   <= ST_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            arvalid_q <= 1'b0;
            bready_q  <= 1'b0;
            rready_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        awvalid_q <= i_word_write;
                        wvalid_q  <= i_word_write;
                        arvalid_q <= !i_word_write;
                        state_q   <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (write_q) begin
                        // Address and data may complete in different cycles.
                        if (i_awready) awvalid_q <= 1'b0;
                        if (i_wready)  wvalid_q  <= 1'b0;
                        if ((!awvalid_q || i_awready) && (!wvalid_q || i_wready)) begin
                            bready_q <= 1'b1;
                            state_q  <= ST_RESP;
                        end
                    end else if (i_arready) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= ST_RESP;
                    end
                end
                default: begin
                    if (b_fire || r_fire) begin
                        bready_q <= 1'b0;
                        rready_q <= 1'b0;
                        done_q   <= 1'b1;
                        state_q  <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Request latch and response capture.
    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= i_word_write;
            addr_q  <= i_word_addr;
            wdata_q <= i_word_wdata;
        end
        if (b_fire) resp_q <= i_bresp;
        if (r_fire) begin
            resp_q  <= i_rresp;
            rdata_q <= i_rdata;
        end
    end

    assign o_word_done  = done_q;
    assign o_word_resp  = resp_q;
    assign o_word_rdata = rdata_q;
    assign o_awvalid    = awvalid_q;
    assign o_awaddr     = addr_q;
    assign o_wvalid     = wvalid_q;
    assign o_wdata      = wdata_q;
    assign o_bready     = bready_q;
    assign o_arvalid    = arvalid_q;
    assign o_araddr     = addr_q;
    assign o_rready     = rready_q;

    // A valid may only fall after the slave took it.
    a_aw_hold : assert property (@(posedge clk) disable iff (i_reset)
        $fell(o_awvalid) |-> $past(i_awready));
    a_w_hold  : assert property (@(posedge clk) disable iff (i_reset)
        $fell(o_wvalid) |-> $past(i_wready));
    a_ar_hold : assert property (@(posedge clk) disable iff (i_reset)
        $fell(o_arvalid) |-> $past(i_arready));

endmodule

//--- source/word_memory.sv
`include "block_xfer_macros.svh"

module word_memory
    import block_xfer_pkg::*;
(
    input  logic  clk,
    input  logic  i_reset,
    input  logic  i_awvalid,
    input  addr_t i_awaddr,
    output logic  o_awready,
    input  logic  i_wvalid,
    input  word_t i_wdata,
    output logic  o_wready,
    output logic  o_bvalid,
    output resp_t o_bresp,
    input  logic  i_bready,
    input  logic  i_arvalid,
    input  addr_t i_araddr,
    output logic  o_arready,
    output logic  o_rvalid,
    output word_t o_rdata,
    output resp_t o_rresp,
    input  logic  i_rready
);

    localparam int unsigned IDX_BITS = $clog2(`MEM_WORDS);

    word_t mem [`MEM_WORDS];

    logic  bvalid_q;
    logic  rvalid_q;
    resp_t bresp_q;
    resp_t rresp_q;
    word_t rdata_q;

    logic  slave_idle;
    logic  wr_req;
    logic  rd_fire;
    logic  wr_ok;
    logic  rd_ok;
    addr_t wr_word;
    addr_t rd_word;

    //----------------------------------------
    // Handshake with priority for writes.
    //----------------------------------------
    assign slave_idle = !bvalid_q && !rvalid_q;
    assign wr_req     = i_awvalid && i_wvalid;
    assign o_awready  = slave_idle && wr_req;
    assign o_wready   = o_awready;
    assign o_arready  = slave_idle && !wr_req && i_arvalid;
    assign rd_fire    = o_arready && i_arvalid;

    // Word index and range check.
    assign wr_word = i_awaddr / addr_t'(`WORD_BYTES);
    assign rd_word = i_araddr / addr_t'(`WORD_BYTES);
    assign wr_ok   = (wr_word < addr_t'(`MEM_WORDS));
    assign rd_ok   = (rd_word < addr_t'(`MEM_WORDS));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (o_awready)     bvalid_q <= 1'b1;
            else if (i_bready) bvalid_q <= 1'b0;
            if (rd_fire)       rvalid_q <= 1'b1;
            else if (i_rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (o_awready) begin
            bresp_q <= wr_ok ? OKAY : SLVERR;
            if (wr_ok) mem[wr_word[IDX_BITS - 1:0]] <= i_wdata;
        end
        if (rd_fire) begin
            rresp_q <= rd_ok ? OKAY : SLVERR;
            rdata_q <= rd_ok ? mem[rd_word[IDX_BITS - 1:0]] : '0;
        end
    end

    assign o_bvalid = bvalid_q;
    assign o_bresp  = bresp_q;
    assign o_rvalid = rvalid_q;
    assign o_rdata  = rdata_q;
    assign o_rresp  = rresp_q;

    // The master never asks for a write and a read at once.
    a_one_request : assert property (@(posedge clk) disable iff (i_reset)
        !((i_awvalid || i_wvalid) && i_arvalid));

endmodule

//--- verif/block_xfer_input.txt
# Columns: operation (R read, W write), block address in hex, expected fault.
# Blocks at 0400 and above lie beyond the memory and must fault.
W 0000 0
R 0000 0
W 0020 0
W 0000 0
R 0000 0
R 0020 0
W 0400 1
R 0000 0
R 0400 1
W 03e0 0
R 03e0 0
W fc00 1
R 0020 0
W 0100 0
R 0100 0
W 0020 0
R 03e0 0
R 0020 0
W 0040 0
R 0040 0
W ffe0 1
R 0100 0
R 0040 0

//--- verif/block_xfer_tb.sv
`include "block_xfer_macros.svh"

module block_xfer_tb
    import block_xfer_pkg::*;
();

    localparam int CYCLES_PER_TEST = `BLOCK_WORDS * 8 + 20;

    logic   clk;
    logic   i_reset;
    logic   i_start_read;
    logic   i_start_write;
    addr_t  i_addr;
    block_t i_block_data;
    logic   o_busy;
    logic   o_done;
    logic   o_fault;
    block_t o_block_data;

    // Test list read from the input file.
    logic [7:0] test_op [$];
    addr_t      test_addr [$];
    logic       test_fault [$];

    word_t model [`MEM_WORDS];
    word_t seed          = 32'h83b0d2c3;
    int    cycle_count   = 0;
    int    cycle_limit   = 0;
    int    done_count    = 0;
    int    done_expected = 0;
    int    error_count   = 0;
    int    tests_ok      = 0;
    int    tests_bad     = 0;
    bit    file_ok;

    block_xfer_top dut (
        .clk           ( clk           ),
        .i_reset       ( i_reset       ),
        .i_start_read  ( i_start_read  ),
        .i_start_write ( i_start_write ),
        .i_addr        ( i_addr        ),
        .i_block_data  ( i_block_data  ),
        .o_busy        ( o_busy        ),
        .o_done        ( o_done        ),
        .o_fault       ( o_fault       ),
        .o_block_data  ( o_block_data  )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit and completion counter.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!i_reset && o_done) done_count <= done_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: o_done missing, run passed %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    function automatic word_t next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    //----------------------------------------
    // Input file.
    //----------------------------------------
    task automatic load_tests();
        int                 fd;
        int                 code;
        int                 fault_val;
        logic [7:0]         op_chr;
        addr_t              addr;
        logic [8*128 - 1:0] line_buf;
        fd = $fopen("verif/block_xfer_input.txt", "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", op_chr);
                if (code == 1) begin
                    if (op_chr == "#") begin
                        code = $fgets(line_buf, fd);
                    end else begin
                        code = $fscanf(fd, "%h %d", addr, fault_val);
                        test_op.push_back(op_chr);
                        test_addr.push_back(addr);
                        test_fault.push_back(fault_val != 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Compare the returned block with the model.
    task automatic check_block(input addr_t addr);
        int    base;
        word_t expected;
        base = int'(addr) / `WORD_BYTES;
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
            expected = model[base + i];
            if (o_block_data[i] !== expected) begin
                $display("mismatch at %0t: o_block_data[%0d] expected %h, got %h",
                         $time, i, expected, o_block_data[i]);
                error_count++;
            end
        end
    endtask

    //----------------------------------------
    // One block transfer.
    //----------------------------------------
    task automatic run_test(input int idx);
        logic [7:0] op;
        addr_t      addr;
        logic       fault_exp;
        block_t     wdata;
        int         errors_before;
        int         base;
        op            = test_op[idx];
        addr          = test_addr[idx];
        fault_exp     = test_fault[idx];
        errors_before = error_count;
        base          = int'(addr) / `WORD_BYTES;
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
            wdata[i] = next_random();
        end
        @(posedge clk);
        i_start_read  <= (op == "R");
        i_start_write <= (op != "R");
        i_addr        <= addr;
        i_block_data  <= wdata;
        @(posedge clk);
        i_start_read  <= 1'b0;
        i_start_write <= 1'b0;
        // Stray strobe in the other direction while the engine is busy.
        @(posedge clk);
        i_start_read  <= (op != "R");
        i_start_write <= (op == "R");
        i_addr        <= addr ^ addr_t'(`BLOCK_WORDS * `WORD_BYTES);
        i_block_data  <= ~wdata;
        @(negedge clk);
        if (o_busy !== 1'b1) begin
            $display("mismatch at %0t: o_busy expected 1, got %b", $time, o_busy);
            error_count++;
        end
        @(posedge clk);
        i_start_read  <= 1'b0;
        i_start_write <= 1'b0;
        do @(negedge clk); while (o_done !== 1'b1);
        done_expected++;
        if (o_fault !== fault_exp) begin
            $display("mismatch at %0t: o_fault expected %0b, got %0b", $time, fault_exp, o_fault);
            error_count++;
        end
        if (op == "R" && !fault_exp) check_block(addr);
        if (op != "R" && !fault_exp) begin
            for (int i = 0; i < `BLOCK_WORDS; i++) begin
                model[base + i] = wdata[i];
            end
        end
        // Room for any extra completion to show up.
        repeat (3) @(negedge clk);
        if (done_count != done_expected) begin
            $display("o_done pulsed %0d times in total where %0d were expected",
                     done_count, done_expected);
            error_count++;
        end
        if (o_busy !== 1'b0) begin
            $display("mismatch at %0t: o_busy expected 0, got %b", $time, o_busy);
            error_count++;
        end
        if (error_count == errors_before) tests_ok++;
        else tests_bad++;
        $display("case %0d: %s addr %h fault %0b %s", idx, op, addr, fault_exp,
                 (error_count == errors_before) ? "ok" : "bad");
    endtask

    initial begin
        i_reset       <= 1'b1;
        i_start_read  <= 1'b0;
        i_start_write <= 1'b0;
        i_addr        <= '0;
        i_block_data  <= '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model[i] = '0;
        end
        load_tests();
        if (!file_ok) begin
            $display("could not open verif/block_xfer_input.txt");
            $display("test failed");
            $finish;
        end else begin
            cycle_limit = test_op.size() * CYCLES_PER_TEST;
            repeat (3) @(posedge clk);
            i_reset <= 1'b0;
            @(negedge clk);
            if (o_done !== 1'b0) begin
                $display("mismatch at %0t: o_done expected 0, got %b", $time, o_done);
                error_count++;
            end
            if (o_fault !== 1'b0) begin
                $display("mismatch at %0t: o_fault expected 0, got %b", $time, o_fault);
                error_count++;
            end
            if (o_busy !== 1'b0) begin
                $display("mismatch at %0t: o_busy expected 0, got %b", $time, o_busy);
                error_count++;
            end
            for (int i = 0; i < test_op.size(); i++) begin
                run_test(i);
            end
            $display("%0d cases: %0d ok, %0d bad, %0d errors",
                     test_op.size(), tests_ok, tests_bad, error_count);
            if (tests_bad == 0 && error_count == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule
